// ==== files.f ====
+incdir+include
logic/cfg_packet_pkg.sv
logic/cfg_host_pkg.sv
logic/cfg_send_if.sv
logic/cfg_apb_host.sv
logic/cfg_packet_serializer.sv
logic/cfg_dst_capture.sv
logic/cfg_node.sv
logic/cfg_net_top.sv
testbench/cfg_net_tb.sv

// ==== include/cfg_net_defs.svh ====
`ifndef CFG_NET_DEFS_SVH
`define CFG_NET_DEFS_SVH

// node addressing
`define CFG_ID_WIDTH 4
`define CFG_LEN_WIDTH 8 // packet length field

// payload framing, a zero goes in after every frame of payload bits
`define CFG_FRAME_LEN 8
`define CFG_MAX_DATA_BITS 16 // widest node sets the shared payload
// received data field, payload plus frame bits plus closing zero
`define CFG_RX_BITS (`CFG_MAX_DATA_BITS + `CFG_MAX_DATA_BITS / `CFG_FRAME_LEN + 1)
`define CFG_PACKET_BITS 36

// network reset, ones in a row
`define CFG_RESET_LEN 10 // what a node needs to see
`define CFG_RESET_SEND 12 // what the serializer sends, with some margin

`define CFG_SYNC_LEN 3 // sync stages before the two edge-detect flops
`define CFG_APB_ADDR_WIDTH 4

`endif

// ==== logic/cfg_apb_host.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_apb_host (
  input  logic                    clk,
  input  logic                    cfg_reset,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  cfg_host_pkg::apb_addr_t paddr,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  cfg_send_if.host                send
);

  localparam int ID_BITS   = $bits(cfg_packet_pkg::node_id_t);
  localparam int DATA_BITS = $bits(cfg_packet_pkg::payload_t);
  localparam int CTRL_BITS = $bits(cfg_host_pkg::ctrl_s);

  cfg_packet_pkg::node_id_t node_id_r;
  cfg_packet_pkg::payload_t data_r;
  cfg_host_pkg::ctrl_s      ctrl_wr;
  logic                     access;     // apb access phase
  logic                     ctrl_write;
  logic                     acc_err;

  assign access     = psel & penable;
  assign ctrl_write = access & pwrite & (paddr == cfg_host_pkg::REG_CTRL);
  assign ctrl_wr    = pwdata[CTRL_BITS-1:0];

  assign pready = 1'b1; // no wait states

  // register writes
  always_ff @(posedge clk) begin
    if (cfg_reset) begin
      node_id_r <= '0;
      data_r    <= '0;
    end else if (access && pwrite) begin
      if (paddr == cfg_host_pkg::REG_NODE_ID) node_id_r <= pwdata[ID_BITS-1:0];
      if (paddr == cfg_host_pkg::REG_DATA) data_r <= pwdata[DATA_BITS-1:0];
    end
  end

  // start pulses last exactly the access phase, so the serializer
  // loads on the same edge that ends the transfer
  assign send.send_packet = ctrl_write & ~send.busy & ctrl_wr.send_packet;
  assign send.send_reset  = ctrl_write & ~send.busy & ctrl_wr.send_reset;
  assign send.node_id     = node_id_r;
  assign send.payload     = data_r;

  // read mux and error decode
  always_comb begin
    prdata  = '0;
    acc_err = 1'b0;
    case (cfg_host_pkg::reg_addr_e'(paddr))
      cfg_host_pkg::REG_NODE_ID: prdata[ID_BITS-1:0] = node_id_r;
      cfg_host_pkg::REG_DATA:    prdata[DATA_BITS-1:0] = data_r;
      cfg_host_pkg::REG_CTRL:    acc_err = pwrite & send.busy; // dropped while a send runs
      cfg_host_pkg::REG_STATUS: begin
        prdata[0] = send.busy;
        acc_err   = pwrite; // read only
      end
      default: acc_err = 1'b1; // hole in the map
    endcase
  end

  assign pslverr = access & acc_err;

endmodule

`default_nettype wire

// ==== logic/cfg_dst_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_net_defs.svh"

module cfg_dst_capture #(
  parameter type data_t = logic [7:0],
  parameter data_t default_value = '0
) (
  input  logic  dst_clk,
  input  logic  dst_reset,
  input  data_t src_data,  // clk domain, held since before the toggle
  input  logic  src_ready, // clk domain toggle
  output data_t data
);

  localparam int SYNC_W = `CFG_SYNC_LEN + 2; // plus edge-detect pair

  logic [SYNC_W-1:0] sync_r;      // toggle enters at the top
  logic              dst_reset_r; // last value of dst_reset
  logic              capture_en;
  logic              default_en;
  data_t             data_r;

  // a toggle shows up as differing bottom stages
  assign capture_en = sync_r[0] ^ sync_r[1];
  // rising edge of dst_reset only
  assign default_en = dst_reset & ~dst_reset_r;

  always_ff @(posedge dst_clk) begin
    sync_r      <= {src_ready, sync_r[SYNC_W-1:1]};
    dst_reset_r <= dst_reset;
  end

  always_ff @(posedge dst_clk) begin
    if (default_en) data_r <= default_value;
    else if (capture_en) data_r <= src_data; // src_data settled by now
  end

  assign data = data_r;

endmodule

`default_nettype wire

// ==== logic/cfg_host_pkg.sv ====
`default_nettype none

`include "cfg_net_defs.svh"

package cfg_host_pkg;

  typedef logic [`CFG_APB_ADDR_WIDTH-1:0] apb_addr_t;

  // register offsets
  typedef enum apb_addr_t {
    REG_NODE_ID = 4'h0, // rw, target node
    REG_DATA    = 4'h4, // rw, payload
    REG_CTRL    = 4'h8, // wo, start bits
    REG_STATUS  = 4'hC  // ro, busy in bit 0
  } reg_addr_e;

  typedef struct packed {
    logic send_reset;  // bit 1
    logic send_packet; // bit 0
  } ctrl_s;

endpackage

`default_nettype wire

// ==== logic/cfg_net_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_net_top (
  input  logic                    clk,
  input  logic                    cfg_reset,
  input  logic                    dst_clk,
  input  logic                    dst_reset,
  input  logic                    psel,
  input  logic                    penable,
  input  logic                    pwrite,
  input  cfg_host_pkg::apb_addr_t paddr,
  input  logic [31:0]             pwdata,
  output logic [31:0]             prdata,
  output logic                    pready,
  output logic                    pslverr,
  output logic [7:0]              cfg_data_a,
  output logic [11:0]             cfg_data_b,
  output logic [15:0]             cfg_data_c
);

  logic cfg_bit; // broadcast serial line

  cfg_send_if send_if ();

  cfg_apb_host i_cfg_apb_host (
    .clk       (clk),
    .cfg_reset (cfg_reset),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .send      (send_if.host)
  );

  cfg_packet_serializer i_cfg_packet_serializer (
    .clk       (clk),
    .cfg_reset (cfg_reset),
    .send      (send_if.serializer),
    .cfg_bit   (cfg_bit)
  );

  cfg_node #(.id(4'd1), .data_t(logic [7:0]), .default_value(8'h5A)) i_cfg_node_a (
    .clk (clk), .cfg_reset (cfg_reset), .cfg_bit (cfg_bit),
    .dst_clk (dst_clk), .dst_reset (dst_reset), .data (cfg_data_a)
  );

  cfg_node #(.id(4'd2), .data_t(logic [11:0]), .default_value(12'h000)) i_cfg_node_b (
    .clk (clk), .cfg_reset (cfg_reset), .cfg_bit (cfg_bit),
    .dst_clk (dst_clk), .dst_reset (dst_reset), .data (cfg_data_b)
  );

  cfg_node #(.id(4'd3), .data_t(logic [15:0]), .default_value(16'hBEEF)) i_cfg_node_c (
    .clk (clk), .cfg_reset (cfg_reset), .cfg_bit (cfg_bit),
    .dst_clk (dst_clk), .dst_reset (dst_reset), .data (cfg_data_c)
  );

endmodule

`default_nettype wire

// ==== logic/cfg_node.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_net_defs.svh"

module cfg_node #(
  parameter cfg_packet_pkg::node_id_t id = 4'd1,
  parameter type data_t = logic [7:0],
  parameter data_t default_value = '0
) (
  input  logic  clk,
  input  logic  cfg_reset,
  input  logic  cfg_bit,
  input  logic  dst_clk,
  input  logic  dst_reset,
  output data_t data
);

  localparam int PKT_W  = $bits(cfg_packet_pkg::node_packet_s);
  localparam int STRIDE = `CFG_FRAME_LEN + 1;

  cfg_packet_pkg::node_packet_s shift_r;    // mirrors the packet layout
  cfg_packet_pkg::pkt_len_t     count_r;    // bypass counter
  cfg_packet_pkg::payload_t     rx_payload; // de-framed rx field
  data_t                        data_r;     // payload register, clk domain
  logic                         ready_r;    // toggles once per new value
  logic                         stream_reset;
  logic                         count_zero;
  logic                         pkt_valid;
  logic                         id_match;
  logic                         data_en;

  // new bits come in at the top and walk down to bit 0
  always_ff @(posedge clk) begin
    if (cfg_reset) shift_r <= '0;
    else shift_r <= {cfg_bit, shift_r[PKT_W-1:1]};
  end

  // run of ones in the low bits resets the stream state
  assign stream_reset = &shift_r[`CFG_RESET_LEN-1:0];
  assign count_zero   = ~|count_r;
  // contents are only looked at when the counter has run out
  assign pkt_valid    = count_zero & (shift_r.valid == cfg_packet_pkg::VALID_PATTERN);
  assign id_match     = shift_r.id == id;
  assign data_en      = pkt_valid & id_match;

  // skip the rest of this packet
  always_ff @(posedge clk) begin
    if (cfg_reset || stream_reset) begin
      count_r <= '0;
    end else if (pkt_valid) begin
      count_r <= shift_r.len - cfg_packet_pkg::pkt_len_t'(1);
    end else if (!count_zero) begin
      count_r <= count_r - cfg_packet_pkg::pkt_len_t'(1);
    end
  end

  // drop the zero after each frame, top bit is the closing zero
  always_comb begin
    rx_payload = '0;
    for (int i = 0; i < `CFG_RX_BITS - 1; i++) begin
      if ((i + 1) % STRIDE != 0) rx_payload[i - i / STRIDE] = shift_r.rx[i];
    end
  end

  always_ff @(posedge clk) begin
    if (cfg_reset || stream_reset) begin
      data_r  <= default_value;
      ready_r <= 1'b0;
    end else if (data_en) begin
      data_r  <= rx_payload[$bits(data_t)-1:0]; // narrow nodes keep the low bits
      ready_r <= ~ready_r;
    end
  end

  // hand over to the destination domain
  cfg_dst_capture #(
    .data_t        (data_t),
    .default_value (default_value)
  ) i_cfg_dst_capture (
    .dst_clk   (dst_clk),
    .dst_reset (dst_reset),
    .src_data  (data_r),
    .src_ready (ready_r),
    .data      (data)
  );

endmodule

`default_nettype wire

// ==== logic/cfg_packet_pkg.sv ====
`default_nettype none

`include "cfg_net_defs.svh"

package cfg_packet_pkg;

  typedef logic [`CFG_ID_WIDTH-1:0] node_id_t;
  typedef logic [`CFG_LEN_WIDTH-1:0] pkt_len_t;
  typedef logic [`CFG_MAX_DATA_BITS-1:0] payload_t; // shared by every node

  // packet as it sits in a node shift register, lsb arrives first
  typedef struct packed {
    logic [`CFG_RX_BITS-1:0] rx; // framed payload
    logic f2;
    node_id_t id;
    logic f1;
    pkt_len_t len; // whole packet length in bits
    logic f0;
    logic [1:0] valid;
  } node_packet_s;

  // 0 goes out first, then 1
  localparam logic [1:0] VALID_PATTERN = 2'b10;

endpackage

`default_nettype wire

// ==== logic/cfg_packet_serializer.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cfg_net_defs.svh"

module cfg_packet_serializer (
  input  logic           clk,
  input  logic           cfg_reset,
  cfg_send_if.serializer send,
  output logic           cfg_bit
);

  localparam int PKT_W  = $bits(cfg_packet_pkg::node_packet_s);
  localparam int CNT_W  = $clog2(`CFG_PACKET_BITS + 1);
  localparam int STRIDE = `CFG_FRAME_LEN + 1; // payload frame plus its zero

  // ones in the low bits, the rest idles at zero
  localparam logic [PKT_W-1:0] RESET_IMAGE =
    {{(PKT_W - `CFG_RESET_SEND){1'b0}}, {`CFG_RESET_SEND{1'b1}}};

  logic [PKT_W-1:0] shift_r; // goes out from bit 0
  logic [CNT_W-1:0] count_r; // bits still to send
  logic             busy;
  logic             start_packet;
  logic             start_reset;

  // payload with a zero after every frame, closing zero on top
  function automatic cfg_packet_pkg::node_packet_s build_packet(
    input cfg_packet_pkg::node_id_t node_id,
    input cfg_packet_pkg::payload_t payload
  );
    cfg_packet_pkg::node_packet_s pkt;
    pkt = '0; // all frame bits zero
    for (int i = 0; i < `CFG_RX_BITS - 1; i++) begin
      if ((i + 1) % STRIDE != 0) pkt.rx[i] = payload[i - i / STRIDE];
    end
    pkt.id    = node_id;
    pkt.len   = cfg_packet_pkg::pkt_len_t'(`CFG_PACKET_BITS); // fixed, one layout for all
    pkt.valid = cfg_packet_pkg::VALID_PATTERN;
    return pkt;
  endfunction

  assign busy         = |count_r;
  assign start_reset  = send.send_reset & ~busy; // reset wins if both are set
  assign start_packet = send.send_packet & ~busy & ~send.send_reset;

  always_ff @(posedge clk) begin
    if (cfg_reset) count_r <= '0;
    else if (start_reset) count_r <= CNT_W'(`CFG_RESET_SEND);
    else if (start_packet) count_r <= CNT_W'(`CFG_PACKET_BITS);
    else if (busy) count_r <= count_r - CNT_W'(1);
  end

  always_ff @(posedge clk) begin
    if (start_reset) shift_r <= RESET_IMAGE;
    else if (start_packet) shift_r <= build_packet(send.node_id, send.payload);
    else shift_r <= shift_r >> 1;
  end

  assign send.busy = busy;
  assign cfg_bit   = busy & shift_r[0]; // line idles low

endmodule

`default_nettype wire

// ==== logic/cfg_send_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// host block to serializer
interface cfg_send_if;

  logic send_packet; // one cycle start
  logic send_reset;  // one cycle start of the all-ones sequence
  cfg_packet_pkg::node_id_t node_id;
  cfg_packet_pkg::payload_t payload;
  logic busy; // high from the cycle after a start until the last bit is out

  modport host (
    output send_packet, send_reset, node_id, payload,
    input  busy
  );

  modport serializer (
    input  send_packet, send_reset, node_id, payload,
    output busy
  );

endinterface

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run from the project root, the simulator exit status is the result
cd "$(dirname "$0")" &&
  verilator --binary --timing -f files.f --top-module cfg_net_tb -o cfg_net_sim &&
  ./obj_dir/cfg_net_sim || exit 1

// ==== testbench/cfg_net_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cfg_net_tb;

  localparam int MAX_VEC = 64;
  localparam logic [31:0] FROM_MODEL = 32'hffff_ffff; // output column follows the write history

  logic clk;
  logic cfg_reset;
  logic dst_clk;
  logic dst_reset;
  logic psel;
  logic penable;
  logic pwrite;
  cfg_host_pkg::apb_addr_t paddr;
  logic [31:0] pwdata;
  logic [31:0] prdata;
  logic pready;
  logic pslverr;
  logic [7:0] cfg_data_a;
  logic [11:0] cfg_data_b;
  logic [15:0] cfg_data_c;

  logic [7:0]  vec_kind [MAX_VEC]; // one entry per vector line
  logic [31:0] vec_id [MAX_VEC];   // node id, or address for bad accesses
  logic [31:0] vec_data [MAX_VEC];
  logic [31:0] vec_err [MAX_VEC];
  logic [31:0] vec_a [MAX_VEC];
  logic [31:0] vec_b [MAX_VEC];
  logic [31:0] vec_c [MAX_VEC];
  int num_vec;
  logic vectors_loaded;
  integer seed;

  // last write per node, known drops after a network reset
  logic [7:0] mdl_a;
  logic [11:0] mdl_b;
  logic [15:0] mdl_c;
  logic known_a, known_b, known_c;

  cfg_net_top i_cfg_net_top (
    .clk (clk), .cfg_reset (cfg_reset), .dst_clk (dst_clk), .dst_reset (dst_reset),
    .psel (psel), .penable (penable), .pwrite (pwrite), .paddr (paddr),
    .pwdata (pwdata), .prdata (prdata), .pready (pready), .pslverr (pslverr),
    .cfg_data_a (cfg_data_a), .cfg_data_b (cfg_data_b), .cfg_data_c (cfg_data_c)
  );

  always #5 clk = ~clk;         // 10 ns
  always #7 dst_clk = ~dst_clk; // 14 ns, unrelated to clk

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_data_a(input logic [7:0] exp);
    if (cfg_data_a !== exp)
      fail_run($sformatf("Error at %0t ns: cfg_data_a expected %h got %h",
                         $time, exp, cfg_data_a));
  endtask

  task automatic check_data_b(input logic [11:0] exp);
    if (cfg_data_b !== exp)
      fail_run($sformatf("Error at %0t ns: cfg_data_b expected %h got %h",
                         $time, exp, cfg_data_b));
  endtask

  task automatic check_data_c(input logic [15:0] exp);
    if (cfg_data_c !== exp)
      fail_run($sformatf("Error at %0t ns: cfg_data_c expected %h got %h",
                         $time, exp, cfg_data_c));
  endtask

  task automatic check_resp(input logic err, input logic [31:0] rdata, input logic exp_err,
                            input logic [31:0] exp_rdata, input logic chk_rdata);
    if (err !== exp_err)
      fail_run($sformatf("Error at %0t ns: pslverr expected %b got %b", $time, exp_err, err));
    if (chk_rdata && rdata !== exp_rdata)
      fail_run($sformatf("Error at %0t ns: prdata expected %h got %h",
                         $time, exp_rdata, rdata));
  endtask

  // setup phase, then access phase, sampled mid access
  task automatic apb_access(input logic wr, input cfg_host_pkg::apb_addr_t addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #2;
    rdata = prdata;
    err   = pslverr;
    if (pready !== 1'b1) fail_run("pready was low during an access phase");
    @(negedge clk);
    psel    = 1'b0; // transfer closed on the rising edge before this
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic apb_write(input cfg_host_pkg::apb_addr_t addr, input logic [31:0] wdata,
                           input logic exp_err);
    logic [31:0] rd;
    logic err;
    apb_access(1'b1, addr, wdata, rd, err);
    check_resp(err, rd, exp_err, 32'h0, 1'b0);
  endtask

  task automatic apb_read(input cfg_host_pkg::apb_addr_t addr, input logic [31:0] exp_rdata,
                          input logic exp_err, input logic chk_rdata);
    logic [31:0] rd;
    logic err;
    apb_access(1'b0, addr, 32'h0, rd, err);
    check_resp(err, rd, exp_err, exp_rdata, chk_rdata);
  endtask

  // load id and payload, read both back, then start the send
  task automatic send_node(input cfg_packet_pkg::node_id_t id,
                           input cfg_packet_pkg::payload_t payload, input logic exp_err);
    apb_write(cfg_host_pkg::REG_NODE_ID, {28'h0, id}, 1'b0);
    apb_write(cfg_host_pkg::REG_DATA, {16'h0, payload}, 1'b0);
    apb_read(cfg_host_pkg::REG_NODE_ID, {28'h0, id}, 1'b0, 1'b1);
    apb_read(cfg_host_pkg::REG_DATA, {16'h0, payload}, 1'b0, 1'b1);
    apb_write(cfg_host_pkg::REG_CTRL, 32'h1, exp_err);
  endtask

  task automatic wait_idle();
    logic [31:0] rd;
    logic err;
    rd = 32'h1;
    while (rd[0]) begin // busy in STATUS bit 0
      apb_access(1'b0, cfg_host_pkg::REG_STATUS, 32'h0, rd, err);
      check_resp(err, rd, 1'b0, 32'h0, 1'b0);
    end
    repeat (30) @(posedge dst_clk); // node write plus synchronizer, with room
    @(negedge dst_clk);
  endtask

  task automatic record_write(input cfg_packet_pkg::node_id_t id,
                              input cfg_packet_pkg::payload_t payload);
    case (id)
      4'd1: begin
        mdl_a   = payload[7:0]; // narrow nodes keep the low bits
        known_a = 1'b1;
      end
      4'd2: begin
        mdl_b   = payload[11:0];
        known_b = 1'b1;
      end
      4'd3: begin
        mdl_c   = payload;
        known_c = 1'b1;
      end
      default: ; // no node answers this id
    endcase
  endtask

  task automatic check_outputs(input int v);
    if (vec_a[v] !== FROM_MODEL) check_data_a(vec_a[v][7:0]);
    else if (known_a) check_data_a(mdl_a);
    if (vec_b[v] !== FROM_MODEL) check_data_b(vec_b[v][11:0]);
    else if (known_b) check_data_b(mdl_b);
    if (vec_c[v] !== FROM_MODEL) check_data_c(vec_c[v][15:0]);
    else if (known_c) check_data_c(mdl_c);
  endtask

  // budget per vector plus one slot for the reset phase
  initial begin
    wait (vectors_loaded);
    #((num_vec + 1) * 1000);
    fail_run("run timed out before all vectors finished");
  end

  initial begin
    int fd;
    int n;
    string line;
    logic [7:0] kind;
    logic [31:0] f_id, f_data, f_err, f_a, f_b, f_c;
    cfg_packet_pkg::node_id_t id;
    cfg_packet_pkg::payload_t payload;
    clk            = 1'b0;
    dst_clk        = 1'b0;
    cfg_reset      = 1'b1;
    dst_reset      = 1'b0; // low first so the rising edge is seen
    psel           = 1'b0;
    penable        = 1'b0;
    pwrite         = 1'b0;
    paddr          = '0;
    pwdata         = '0;
    vectors_loaded = 1'b0;
    seed           = 32'h204f;
    mdl_a          = 8'h5A;
    mdl_b          = 12'h000;
    mdl_c          = 16'hBEEF;
    known_a        = 1'b1;
    known_b        = 1'b1;
    known_c        = 1'b1;
    num_vec        = 0;

    fd = $fopen("testbench/cfg_net_vectors.txt", "r");
    if (fd == 0) fail_run("could not open testbench/cfg_net_vectors.txt");
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n > 1 && line.getc(0) != "#") begin
        n = $sscanf(line, "%c %h %h %h %h %h %h", kind, f_id, f_data, f_err, f_a, f_b, f_c);
        if (n != 7) fail_run({"malformed line in vector file: ", line});
        if (num_vec == MAX_VEC) fail_run("vector file holds more lines than the table");
        vec_kind[num_vec] = kind;
        vec_id[num_vec]   = f_id;
        vec_data[num_vec] = f_data;
        vec_err[num_vec]  = f_err;
        vec_a[num_vec]    = f_a;
        vec_b[num_vec]    = f_b;
        vec_c[num_vec]    = f_c;
        num_vec++;
      end
    end
    $fclose(fd);
    vectors_loaded = 1'b1;

    repeat (3) @(posedge clk);
    @(negedge clk);
    cfg_reset = 1'b0;
    @(negedge dst_clk);
    dst_reset = 1'b1; // rising edge loads the defaults
    repeat (3) @(negedge dst_clk);
    dst_reset = 1'b0;
    repeat (10) @(negedge dst_clk);
    check_data_a(8'h5A);
    check_data_b(12'h000);
    check_data_c(16'hBEEF);

    for (int v = 0; v < num_vec; v++) begin
      id      = vec_id[v][3:0];
      payload = vec_data[v][15:0];
      case (vec_kind[v])
        "W", "R": begin
          if (vec_kind[v] == "R") payload = 16'($random(seed));
          send_node(id, payload, vec_err[v][0]);
          record_write(id, payload);
          wait_idle();
        end
        "B": begin
          send_node(id, payload, 1'b0);
          apb_read(cfg_host_pkg::REG_STATUS, 32'h1, 1'b0, 1'b1);
          apb_write(cfg_host_pkg::REG_DATA, {16'h0, ~payload}, 1'b0); // would show if resent
          apb_write(cfg_host_pkg::REG_CTRL, 32'h1, vec_err[v][0]);
          record_write(id, payload);
          wait_idle();
        end
        "A": begin
          apb_write(id, vec_data[v], vec_err[v][0]); // id column is the address
          if (id != cfg_host_pkg::REG_STATUS) apb_read(id, 32'h0, vec_err[v][0], 1'b0);
        end
        "N": begin
          apb_write(cfg_host_pkg::REG_CTRL, 32'h2, vec_err[v][0]);
          known_a = 1'b0; // stream reset leaves outputs open until the next write
          known_b = 1'b0;
          known_c = 1'b0;
          wait_idle();
        end
        default: fail_run($sformatf("unknown kind on vector %0d", v));
      endcase
      check_outputs(v);
    end

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== testbench/cfg_net_vectors.txt ====
# kind id data pslverr cfg_data_a cfg_data_b cfg_data_c, hex; W write, R random write, B busy write
# A bad access at address id, N network reset; ffffffff follows the last write to that node
W 1 00a5 0 a5 000 beef
W 2 39a5 0 a5 9a5 beef
W 3 81c3 0 a5 9a5 81c3
W 4 ffff 0 a5 9a5 81c3
R 1 0000 0 ffffffff 9a5 81c3
R 3 0000 0 ffffffff 9a5 ffffffff
W 2 0fff 0 ffffffff fff ffffffff
W 2 f180 0 ffffffff 180 ffffffff
W 1 ff81 0 81 180 ffffffff
B 3 a5c3 1 81 180 a5c3
A 2 1234 1 81 180 a5c3
A c 0001 1 81 180 a5c3
N 0 0000 0 ffffffff ffffffff ffffffff
W 1 007e 0 7e ffffffff ffffffff
W 2 0801 0 7e 801 ffffffff
W 3 ffff 0 7e 801 ffff
